//--- psx_io_cfg.svh
`ifndef PSX_IO_CFG_SVH
`define PSX_IO_CFG_SVH

// memory control 1 bank, nine consecutive words
`define PSX_MEM_CTRL_1_ADDR   32'h1F80_1000
`define PSX_MEM_CTRL_1_COUNT  9

// memory control 2
`define PSX_RAM_SIZE_ADDR     32'h1F80_1060

// interrupt controller
`define PSX_I_STAT_ADDR       32'h1F80_1070
`define PSX_I_MASK_ADDR       32'h1F80_1074

// gpu ports, read side is GPUREAD / GPUSTAT
`define PSX_GPU_GP0_ADDR      32'h1F80_1810
`define PSX_GPU_GP1_ADDR      32'h1F80_1814

// memory control 1 reset words
`define PSX_MEM_CTRL_1_RST_0  32'h1F00_0000 // exp 1 base
`define PSX_MEM_CTRL_1_RST_1  32'h1F80_2000 // exp 2 base
`define PSX_MEM_CTRL_1_RST_2  32'h0013_243F // exp 1 delay/size
`define PSX_MEM_CTRL_1_RST_3  32'h0000_3022 // exp 3 delay/size
`define PSX_MEM_CTRL_1_RST_4  32'h0013_243F // bios rom delay/size
`define PSX_MEM_CTRL_1_RST_5  32'h2009_31E1 // spu delay/size
`define PSX_MEM_CTRL_1_RST_6  32'h0002_0843 // cdrom delay/size
`define PSX_MEM_CTRL_1_RST_7  32'h0007_0777 // exp 2 delay/size
`define PSX_MEM_CTRL_1_RST_8  32'h0003_1125 // common delay

// ram size register
`define PSX_RAM_SIZE_RST      32'h0000_0B88

// interrupt sources
`define PSX_IRQ_COUNT         11

`endif

//--- psx_io_pkg.sv
`include "psx_io_cfg.svh"

package psx_io_pkg;

   typedef logic [31:0] word_t;  // bus data word
   typedef logic [31:0] addr_t;  // bus address
   typedef logic [3:0]  ben_t;   // bit n enables byte n

   // vblank, gpu, cdrom, dma, timer0..2, ctrl/memcard, sio, spu, lightpen
   typedef logic [`PSX_IRQ_COUNT-1:0] irq_vec_t;

   // 0..8 bank registers, 9 ram size
   typedef logic [3:0] memctl_idx_t;

   // one-hot bus controller states
   typedef enum logic [4:0] {
      ST_IDLE  = 5'b00001,
      ST_READ  = 5'b00010,
      ST_LATCH = 5'b00100,
      ST_WRITE = 5'b01000,
      ST_WAIT  = 5'b10000
   } bus_state_t;

endpackage

//--- io_addr_decode.sv
`timescale 1ns/1ps

`include "psx_io_cfg.svh"

module io_addr_decode (
   input  psx_io_pkg::addr_t       addr_i,
   output logic                    memctl_sel_o,
   output psx_io_pkg::memctl_idx_t memctl_idx_o,
   output logic                    irq_sel_o,
   output logic                    irq_is_mask_o,
   output logic                    gp0_sel_o,
   output logic                    gp1_sel_o
);

   import psx_io_pkg::*;

   localparam addr_t       BANK_BASE    = `PSX_MEM_CTRL_1_ADDR;
   localparam memctl_idx_t RAM_SIZE_IDX = memctl_idx_t'(`PSX_MEM_CTRL_1_COUNT);

   logic is_stat;
   logic is_mask;

   // memory control bank and ram size share one index space
   always_comb begin
      memctl_sel_o = 1'b0;
      memctl_idx_o = '0;
      for (int i = 0; i < `PSX_MEM_CTRL_1_COUNT; i++) begin
         if (addr_i == BANK_BASE + addr_t'(4 * i)) begin
            memctl_sel_o = 1'b1;
            memctl_idx_o = memctl_idx_t'(i);
         end
      end
      if (addr_i == `PSX_RAM_SIZE_ADDR) begin
         memctl_sel_o = 1'b1;
         memctl_idx_o = RAM_SIZE_IDX; // sits right after the bank
      end
   end

   assign is_stat = (addr_i == `PSX_I_STAT_ADDR);
   assign is_mask = (addr_i == `PSX_I_MASK_ADDR);

   assign irq_sel_o     = is_stat | is_mask;
   assign irq_is_mask_o = is_mask; // low means status

   // each gpu address serves a write port and a read port
   assign gp0_sel_o = (addr_i == `PSX_GPU_GP0_ADDR); // gp0 / gpuread
   assign gp1_sel_o = (addr_i == `PSX_GPU_GP1_ADDR); // gp1 / gpustat

endmodule

//--- io_bus_fsm.sv
`timescale 1ns/1ps

module io_bus_fsm (
   input  logic              clk,
   input  logic              rst,
   input  logic              ren_i,
   input  logic              wen_i,
   input  psx_io_pkg::word_t data_i,
   input  logic              memctl_sel_i,
   input  logic              irq_sel_i,
   input  logic              gp0_sel_i,
   input  logic              gp1_sel_i,
   input  psx_io_pkg::word_t memctl_rdata_i,
   input  psx_io_pkg::word_t irq_rdata_i,
   input  psx_io_pkg::word_t gpu_read_i,
   input  psx_io_pkg::word_t gpu_stat_i,
   input  logic              gpu_rdy_i,
   input  logic              gpu_fifo_full_i,
   output logic              ack_o,
   output psx_io_pkg::word_t data_o,
   output logic              memctl_we_o,
   output logic              irq_we_o,
   output logic              to_gp0_o,
   output logic              to_gp1_o,
   output psx_io_pkg::word_t gp0_o,
   output psx_io_pkg::word_t gp1_o,
   output logic              gpu_ren_o
);

   import psx_io_pkg::*;

   bus_state_t state_q;
   bus_state_t state_d;
   word_t      rd_mux;
   word_t      data_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d     = state_q;
      ack_o       = 1'b0;
      memctl_we_o = 1'b0;
      irq_we_o    = 1'b0;
      to_gp0_o    = 1'b0;
      to_gp1_o    = 1'b0;
      gpu_ren_o   = 1'b0;

      case (state_q)
         ST_IDLE: begin
            if (ren_i) begin // read has priority
               state_d = ST_READ;
            end else if (wen_i) begin
               state_d = ST_WRITE;
            end
         end

         ST_READ: begin
            state_d = ST_LATCH; // one cycle step
         end

         ST_LATCH: begin
            // GPUREAD holds off until the gpu has a word
            if (!(gp0_sel_i && !gpu_rdy_i)) begin
               ack_o     = 1'b1;
               gpu_ren_o = gp0_sel_i;
               state_d   = ST_WAIT;
            end
         end

         ST_WRITE: begin
            // gp0 stalls on a full fifo, everything else goes through
            if (!(gp0_sel_i && gpu_fifo_full_i)) begin
               ack_o       = 1'b1;
               memctl_we_o = memctl_sel_i;
               irq_we_o    = irq_sel_i;
               to_gp0_o    = gp0_sel_i;
               to_gp1_o    = gp1_sel_i;
               state_d     = ST_WAIT; // unmapped just acks
            end
         end

         ST_WAIT: begin
            ack_o = 1'b1;
            if (!ren_i && !wen_i) begin // master dropped request
               state_d = ST_IDLE;
            end
         end

         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   // data only valid with its strobe
   assign gp0_o = to_gp0_o ? data_i : '0;
   assign gp1_o = to_gp1_o ? data_i : '0;

   always_comb begin
      if (memctl_sel_i) begin
         rd_mux = memctl_rdata_i;
      end else if (irq_sel_i) begin
         rd_mux = irq_rdata_i;
      end else if (gp0_sel_i) begin
         rd_mux = gpu_read_i;
      end else if (gp1_sel_i) begin
         rd_mux = gpu_stat_i;
      end else begin
         rd_mux = '0; // unmapped reads as zero
      end
   end

   // loaded on the edge that leaves latch
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         data_q <= '0;
      end else if (state_q == ST_LATCH && ack_o) begin
         data_q <= rd_mux;
      end
   end

   assign data_o = data_q;

endmodule

//--- mem_ctrl_regs.sv
`timescale 1ns/1ps

`include "psx_io_cfg.svh"

module mem_ctrl_regs (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    we_i,
   input  psx_io_pkg::memctl_idx_t idx_i,
   input  psx_io_pkg::word_t       data_i,
   input  psx_io_pkg::ben_t        ben_i,
   output psx_io_pkg::word_t       rdata_o
);

   import psx_io_pkg::*;

   localparam int NUM_REGS = `PSX_MEM_CTRL_1_COUNT + 1; // bank plus ram size

   localparam word_t RST_VAL [NUM_REGS] = '{
      `PSX_MEM_CTRL_1_RST_0,
      `PSX_MEM_CTRL_1_RST_1,
      `PSX_MEM_CTRL_1_RST_2,
      `PSX_MEM_CTRL_1_RST_3,
      `PSX_MEM_CTRL_1_RST_4,
      `PSX_MEM_CTRL_1_RST_5,
      `PSX_MEM_CTRL_1_RST_6,
      `PSX_MEM_CTRL_1_RST_7,
      `PSX_MEM_CTRL_1_RST_8,
      `PSX_RAM_SIZE_RST
   };

   word_t regs_q [NUM_REGS];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs_q[i] <= RST_VAL[i];
         end
      end else if (we_i) begin
         for (int b = 0; b < 4; b++) begin
            if (ben_i[b]) begin
               regs_q[idx_i][8*b +: 8] <= data_i[8*b +: 8]; // enabled byte only
            end
         end
      end
   end

   // read-back of the indexed word
   assign rdata_o = regs_q[idx_i];

endmodule

//--- irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 we_i,
   input  logic                 is_mask_i,
   input  psx_io_pkg::word_t    data_i,
   input  psx_io_pkg::ben_t     ben_i,
   input  psx_io_pkg::irq_vec_t irq_src_i,
   output psx_io_pkg::word_t    rdata_o,
   output psx_io_pkg::irq_vec_t stat_o,
   output logic                 irq_o
);

   import psx_io_pkg::*;

   localparam int N = $bits(irq_vec_t);

   irq_vec_t src_q;   // previous source sample
   irq_vec_t stat_q;
   irq_vec_t mask_q;
   irq_vec_t rise;
   irq_vec_t bit_en;  // byte enables spread per bit
   irq_vec_t ack_clr;

   always_comb begin
      for (int i = 0; i < N; i++) begin
         bit_en[i] = ben_i[i / 8];
      end
   end

   assign rise = irq_src_i & ~src_q;

   // writing 0 acknowledges the bit
   assign ack_clr = (we_i && !is_mask_i) ? (bit_en & ~data_i[N-1:0]) : '0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         src_q  <= '0;
         stat_q <= '0;
         mask_q <= '0;
      end else begin
         src_q  <= irq_src_i;
         stat_q <= (stat_q & ~ack_clr) | rise; // new edge beats ack
         if (we_i && is_mask_i) begin
            mask_q <= (mask_q & ~bit_en) | (data_i[N-1:0] & bit_en);
         end
      end
   end

   assign stat_o = stat_q;
   assign irq_o  = |(stat_q & mask_q);

   assign rdata_o = is_mask_i ? word_t'(mask_q) : word_t'(stat_q); // zero extended

endmodule

//--- psx_io_top.sv
`timescale 1ns/1ps

module psx_io_top (
   input  logic                 clk,
   input  logic                 rst,
   input  psx_io_pkg::addr_t    addr_i,
   input  psx_io_pkg::word_t    data_i,
   input  psx_io_pkg::ben_t     ben_i,
   input  logic                 ren_i,
   input  logic                 wen_i,
   input  logic                 gpu_rdy_i,
   input  logic                 gpu_fifo_full_i,
   input  psx_io_pkg::word_t    gpu_stat_i,
   input  psx_io_pkg::word_t    gpu_read_i,
   input  psx_io_pkg::irq_vec_t irq_src_i,
   output logic                 ack_o,
   output psx_io_pkg::word_t    data_o,
   output logic                 to_gp0_o,
   output logic                 to_gp1_o,
   output psx_io_pkg::word_t    gp0_o,
   output psx_io_pkg::word_t    gp1_o,
   output logic                 gpu_ren_o,
   output psx_io_pkg::irq_vec_t interrupts_o,
   output logic                 irq_o
);

   import psx_io_pkg::*;

   logic        memctl_sel;
   memctl_idx_t memctl_idx;
   logic        irq_sel;
   logic        irq_is_mask;
   logic        gp0_sel;
   logic        gp1_sel;
   logic        memctl_we;
   logic        irq_we;
   word_t       memctl_rdata;
   word_t       irq_rdata;

   io_addr_decode u_decode (
      .addr_i        (addr_i),
      .memctl_sel_o  (memctl_sel),
      .memctl_idx_o  (memctl_idx),
      .irq_sel_o     (irq_sel),
      .irq_is_mask_o (irq_is_mask),
      .gp0_sel_o     (gp0_sel),
      .gp1_sel_o     (gp1_sel)
   );

   io_bus_fsm u_fsm (
      .clk             (clk),
      .rst             (rst),
      .ren_i           (ren_i),
      .wen_i           (wen_i),
      .data_i          (data_i),
      .memctl_sel_i    (memctl_sel),
      .irq_sel_i       (irq_sel),
      .gp0_sel_i       (gp0_sel),
      .gp1_sel_i       (gp1_sel),
      .memctl_rdata_i  (memctl_rdata),
      .irq_rdata_i     (irq_rdata),
      .gpu_read_i      (gpu_read_i),
      .gpu_stat_i      (gpu_stat_i),
      .gpu_rdy_i       (gpu_rdy_i),
      .gpu_fifo_full_i (gpu_fifo_full_i),
      .ack_o           (ack_o),
      .data_o          (data_o),
      .memctl_we_o     (memctl_we),
      .irq_we_o        (irq_we),
      .to_gp0_o        (to_gp0_o),
      .to_gp1_o        (to_gp1_o),
      .gp0_o           (gp0_o),
      .gp1_o           (gp1_o),
      .gpu_ren_o       (gpu_ren_o)
   );

   mem_ctrl_regs u_memctl (
      .clk     (clk),
      .rst     (rst),
      .we_i    (memctl_we),
      .idx_i   (memctl_idx),
      .data_i  (data_i),
      .ben_i   (ben_i),
      .rdata_o (memctl_rdata)
   );

   irq_ctrl u_irq (
      .clk       (clk),
      .rst       (rst),
      .we_i      (irq_we),
      .is_mask_i (irq_is_mask),
      .data_i    (data_i),
      .ben_i     (ben_i),
      .irq_src_i (irq_src_i),
      .rdata_o   (irq_rdata),
      .stat_o    (interrupts_o),
      .irq_o     (irq_o)
   );

endmodule

//--- tb_psx_io.sv
`timescale 1ns/1ps

`include "psx_io_cfg.svh"

module tb_psx_io;

   import psx_io_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 10;
   localparam int MAX_STALL  = 8;
   localparam int NUM_XFERS  = 100; // upper bound over all tests
   localparam int ACK_LIMIT  = MAX_STALL + 4;
   // each transfer costs its stall plus hold, drop and idle cycles
   localparam int WATCHDOG_CYCLES = RST_CYCLES + NUM_XFERS * (MAX_STALL + 10) + 200;

   logic     clk;
   logic     rst;
   addr_t    addr_i;
   word_t    data_i;
   ben_t     ben_i;
   logic     ren_i;
   logic     wen_i;
   logic     gpu_rdy_i;
   logic     gpu_fifo_full_i;
   word_t    gpu_stat_i;
   word_t    gpu_read_i;
   irq_vec_t irq_src_i;
   logic     ack_o;
   word_t    data_o;
   logic     to_gp0_o;
   logic     to_gp1_o;
   word_t    gp0_o;
   word_t    gp1_o;
   logic     gpu_ren_o;
   irq_vec_t interrupts_o;
   logic     irq_o;

   word_t    mc_model [`PSX_MEM_CTRL_1_COUNT + 1];
   irq_vec_t stat_model;
   irq_vec_t mask_model;
   int       errors;
   int       tests_ok;
   int       tests_bad;
   int       gp0_cnt = 0;
   int       gp1_cnt = 0;
   int       ren_cnt = 0;
   word_t    gp0_seen;
   word_t    gp1_seen;

   psx_io_top u_dut (.*);

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // gpu side pulse counters
   always @(negedge clk) begin
      if (to_gp0_o) begin
         gp0_cnt++;
         gp0_seen = gp0_o;
      end
      if (to_gp1_o) begin
         gp1_cnt++;
         gp1_seen = gp1_o;
      end
      if (gpu_ren_o) begin
         ren_cnt++;
      end
   end

   // a gpu strobe belongs to the first cycle of ack
   assert property (@(posedge clk) disable iff (rst)
                    (to_gp0_o || to_gp1_o || gpu_ren_o) |-> (ack_o && !$past(ack_o)))
   else begin
      $display("gpu strobe seen outside the first acknowledge cycle");
      errors++;
   end

   function automatic word_t merge_bytes(word_t old_v, word_t new_v, ben_t be);
      word_t r;
      r = old_v;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            r[8*b +: 8] = new_v[8*b +: 8];
         end
      end
      return r;
   endfunction

   // interrupt registers live in the low two bytes
   function automatic irq_vec_t irq_en(ben_t be);
      return irq_vec_t'({{8{be[1]}}, {8{be[0]}}});
   endfunction

   function automatic addr_t memctl_addr(int idx);
      if (idx < `PSX_MEM_CTRL_1_COUNT) begin
         return `PSX_MEM_CTRL_1_ADDR + addr_t'(4 * idx);
      end
      return `PSX_RAM_SIZE_ADDR;
   endfunction

   task automatic compare_word(input string name, input word_t got, input word_t exp);
      assert (got == exp)
      else begin
         $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_true(input logic cond, input string msg);
      assert (cond)
      else begin
         $display("%s", msg);
         errors++;
      end
   endtask

   // waits for ack, holds a while, drops the request
   task automatic handshake(input int stall, output int lat);
      int hold;
      lat = 0;
      forever begin
         @(negedge clk);
         if (ack_o || lat > ACK_LIMIT) break;
         lat++;
         @(posedge clk);
         if (lat >= stall) begin // stall over, gpu side ready again
            gpu_fifo_full_i <= 1'b0;
            gpu_rdy_i       <= 1'b1;
         end
      end
      expect_true(ack_o, "no acknowledge came from the DUT");
      hold = $urandom_range(2, 0);
      repeat (hold) begin
         @(posedge clk);
         @(negedge clk);
         expect_true(ack_o, "ack_o dropped while the request was still held");
      end
      @(posedge clk);
      ren_i <= 1'b0;
      wen_i <= 1'b0;
      @(negedge clk);
      expect_true(ack_o, "ack_o dropped in the cycle the request fell");
      @(negedge clk);
      expect_true(!ack_o, "ack_o still high after the request dropped");
   endtask

   task automatic bus_write(input addr_t a, input word_t d, input ben_t be, input int stall);
      int lat;
      @(posedge clk);
      addr_i <= a;
      data_i <= d;
      ben_i  <= be;
      wen_i  <= 1'b1;
      handshake(stall, lat);
      compare_word("ack_o write latency", word_t'(lat), word_t'((stall > 1) ? stall : 1));
   endtask

   task automatic bus_read(input addr_t a, input int stall, output word_t d);
      int lat;
      @(posedge clk);
      addr_i <= a;
      ren_i  <= 1'b1;
      handshake(stall, lat);
      d = data_o; // holds until the next read
      compare_word("ack_o read latency", word_t'(lat), word_t'((stall > 2) ? stall : 2));
   endtask

   task automatic report_test(input int num, input string name, input int start);
      if (errors == start) begin
         tests_ok++;
         $display("[%0d] %s: ok", num, name);
      end else begin
         tests_bad++;
         $display("[%0d] %s: %0d errors", num, name, errors - start);
      end
   endtask

   initial begin
      int       start;
      int       idx;
      int       s;
      int       k;
      int       c0;
      word_t    rd;
      word_t    d;
      ben_t     be;
      irq_vec_t clr;
      void'($urandom(32'h2969));
      errors    = 0;
      tests_ok  = 0;
      tests_bad = 0;
      rst             <= 1'b1;
      addr_i          <= '0;
      data_i          <= '0;
      ben_i           <= '0;
      ren_i           <= 1'b0;
      wen_i           <= 1'b0;
      gpu_rdy_i       <= 1'b1;
      gpu_fifo_full_i <= 1'b0;
      gpu_stat_i      <= '0;
      gpu_read_i      <= '0;
      irq_src_i       <= '0;
      stat_model = '0;
      mask_model = '0;
      mc_model   = '{`PSX_MEM_CTRL_1_RST_0, `PSX_MEM_CTRL_1_RST_1, `PSX_MEM_CTRL_1_RST_2,
                     `PSX_MEM_CTRL_1_RST_3, `PSX_MEM_CTRL_1_RST_4, `PSX_MEM_CTRL_1_RST_5,
                     `PSX_MEM_CTRL_1_RST_6, `PSX_MEM_CTRL_1_RST_7, `PSX_MEM_CTRL_1_RST_8,
                     `PSX_RAM_SIZE_RST};
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;

      start = errors;
      @(negedge clk);
      expect_true(!(ack_o || to_gp0_o || to_gp1_o || gpu_ren_o || irq_o),
                  "a control output is high after reset");
      compare_word("gp0_o", gp0_o, '0);
      compare_word("gp1_o", gp1_o, '0);
      compare_word("data_o", data_o, '0);
      compare_word("interrupts_o", word_t'(interrupts_o), '0);
      for (int i = 0; i <= `PSX_MEM_CTRL_1_COUNT; i++) begin
         bus_read(memctl_addr(i), 0, rd);
         compare_word("data_o", rd, mc_model[i]);
      end
      report_test(1, "reset values", start);

      start = errors;
      repeat (16) begin
         idx = $urandom_range(`PSX_MEM_CTRL_1_COUNT, 0);
         d   = $urandom();
         be  = ben_t'($urandom());
         bus_write(memctl_addr(idx), d, be, 0);
         mc_model[idx] = merge_bytes(mc_model[idx], d, be);
         bus_read(memctl_addr(idx), 0, rd);
         compare_word("data_o", rd, mc_model[idx]);
      end
      bus_write(32'h1F80_1024, $urandom(), 4'hF, 0); // just past the bank
      bus_read(32'h1F80_1024, 0, rd);
      compare_word("data_o unmapped", rd, '0);
      for (int i = 0; i <= `PSX_MEM_CTRL_1_COUNT; i++) begin
         bus_read(memctl_addr(i), 0, rd);
         compare_word("data_o", rd, mc_model[i]);
      end
      report_test(2, "byte enable writes", start);

      start = errors;
      repeat (6) begin
         s = $urandom_range(`PSX_IRQ_COUNT - 1, 0);
         @(posedge clk);
         irq_src_i[s] <= 1'b1;
         stat_model[s] = 1'b1;
         @(posedge clk);
         @(negedge clk);
         compare_word("interrupts_o", word_t'(interrupts_o), word_t'(stat_model));
         @(posedge clk);
         irq_src_i[s] <= 1'b0; // falling edge sets nothing
         d  = $urandom();
         be = ben_t'($urandom());
         bus_write(`PSX_I_MASK_ADDR, d, be, 0);
         mask_model = (mask_model & ~irq_en(be)) | (irq_vec_t'(d) & irq_en(be));
         compare_word("irq_o", word_t'(irq_o), word_t'(|(stat_model & mask_model)));
         clr = irq_vec_t'($urandom());
         be  = ben_t'($urandom());
         bus_write(`PSX_I_STAT_ADDR, ~word_t'(clr), be, 0);
         stat_model = stat_model & ~(clr & irq_en(be));
         bus_read(`PSX_I_STAT_ADDR, 0, rd);
         compare_word("data_o i_stat", rd, word_t'(stat_model));
         bus_read(`PSX_I_MASK_ADDR, 0, rd);
         compare_word("data_o i_mask", rd, word_t'(mask_model));
         compare_word("interrupts_o", word_t'(interrupts_o), word_t'(stat_model));
      end
      report_test(3, "interrupt capture", start);

      start = errors;
      k  = $urandom_range(MAX_STALL, 2);
      d  = $urandom();
      c0 = gp0_cnt;
      @(posedge clk);
      gpu_fifo_full_i <= 1'b1;
      bus_write(`PSX_GPU_GP0_ADDR, d, 4'hF, k);
      compare_word("to_gp0_o pulses", word_t'(gp0_cnt - c0), 1);
      compare_word("gp0_o", gp0_seen, d);
      d  = $urandom();
      c0 = gp1_cnt;
      bus_write(`PSX_GPU_GP1_ADDR, d, 4'hF, 0);
      compare_word("to_gp1_o pulses", word_t'(gp1_cnt - c0), 1);
      compare_word("gp1_o", gp1_seen, d);
      report_test(4, "gp0 back-pressure", start);

      start = errors;
      k  = $urandom_range(MAX_STALL, 3);
      d  = $urandom();
      c0 = ren_cnt;
      @(posedge clk);
      gpu_rdy_i  <= 1'b0;
      gpu_read_i <= d;
      bus_read(`PSX_GPU_GP0_ADDR, k, rd);
      compare_word("gpu_ren_o pulses", word_t'(ren_cnt - c0), 1);
      compare_word("data_o gpuread", rd, d);
      d = $urandom();
      @(posedge clk);
      gpu_stat_i <= d;
      bus_read(`PSX_GPU_GP1_ADDR, 0, rd);
      compare_word("data_o gpustat", rd, d);
      report_test(5, "gpuread back-pressure", start);

      // latency and hold are checked inside every transfer
      start = errors;
      repeat (4) begin
         d = $urandom();
         bus_write(`PSX_I_MASK_ADDR, d, 4'h3, 0);
         mask_model = irq_vec_t'(d);
         bus_read(`PSX_I_MASK_ADDR, 0, rd);
         compare_word("data_o i_mask", rd, word_t'(mask_model));
      end
      report_test(6, "handshake", start);

      $display("summary: %0d tests ok, %0d failing, %0d errors",
               tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("test failed");
      $finish;
   end

endmodule

//--- src.f
+incdir+.
psx_io_pkg.sv
io_addr_decode.sv
io_bus_fsm.sv
mem_ctrl_regs.sv
irq_ctrl.sv
psx_io_top.sv
tb_psx_io.sv

//--- Makefile
TOP := tb_psx_io

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
